//--- src/booth_defs.svh
`ifndef BOOTH_DEFS_SVH
`define BOOTH_DEFS_SVH

// operand width of the core.
`define BOOTH_XLEN 64

// wishbone word address width.
`define BOOTH_ADR_W 3

// register map, word addresses.
`define BOOTH_REG_OPA    3'd0
`define BOOTH_REG_OPB    3'd1
`define BOOTH_REG_CTRL   3'd2
`define BOOTH_REG_STATUS 3'd3
`define BOOTH_REG_RESULT 3'd4

// status bits.
`define BOOTH_STAT_BUSY 0
`define BOOTH_STAT_DONE 1

`endif

//--- src/booth_pkg.sv
`include "booth_defs.svh"

package booth_pkg;

  // same encoding as funct3 of the M extension.
  typedef enum logic [1:0]
  {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_e;

  // one multiply request.
  typedef struct packed
  {
    mul_op_e                op;
    logic [`BOOTH_XLEN-1:0] a;
    logic [`BOOTH_XLEN-1:0] b;
  } mul_req_t;

  // selected result word.
  typedef struct packed
  {
    logic [`BOOTH_XLEN-1:0] result;
  } mul_rsp_t;

endpackage

//--- src/riscv_core_booth.sv
module riscv_core_booth
#(
  parameter int XLEN = 64
)
(
  input  logic              i_booth_clk,
  input  logic              i_booth_rstn,
  input  logic              i_booth_en,
  input  logic [XLEN-1:0]   i_booth_multiplicand,
  input  logic [XLEN-1:0]   i_booth_multilpier,
  output logic              o_booth_done,
  output logic [2*XLEN-1:0] o_booth_product
);

  localparam int CNT_W = $clog2(XLEN) + 1;

  typedef enum logic {IDLE, MUL} state_e;

  state_e           state_reg;
  state_e           state_next;
  logic [XLEN-1:0]  mcand_reg;
  logic [XLEN-1:0]  mcand_next;
  logic [XLEN-1:0]  mplier_reg;
  logic [XLEN-1:0]  mplier_next;
  logic [XLEN-1:0]  acc_reg;
  logic [XLEN-1:0]  acc_next;
  logic [XLEN:0]    acc_sum;
  logic [CNT_W-1:0] cnt_reg;
  logic [CNT_W-1:0] cnt_next;

  always_ff @(posedge i_booth_clk or negedge i_booth_rstn)
  begin
    if (!i_booth_rstn)
    begin
      state_reg  <= IDLE;
      mcand_reg  <= '0;
      mplier_reg <= '0;
      acc_reg    <= '0;
      cnt_reg    <= '0;
    end
    else
    begin
      state_reg  <= state_next;
      mcand_reg  <= mcand_next;
      mplier_reg <= mplier_next;
      acc_reg    <= acc_next;
      cnt_reg    <= cnt_next;
    end
  end

  // extra top bit keeps the carry out of the add.
  assign acc_sum = mplier_reg[0] ? ({1'b0, acc_reg} + {1'b0, mcand_reg})
                                 : {1'b0, acc_reg};

  always_comb
  begin
    state_next      = state_reg;
    mcand_next      = mcand_reg;
    mplier_next     = mplier_reg;
    acc_next        = acc_reg;
    cnt_next        = cnt_reg;
    o_booth_done    = 1'b0;
    o_booth_product = '0;
    case (state_reg)
      IDLE:
      begin
        if (i_booth_en)
        begin
          mcand_next  = i_booth_multiplicand;
          mplier_next = i_booth_multilpier;
          acc_next    = '0;
          cnt_next    = CNT_W'(XLEN);
          state_next  = MUL;
        end
      end
      MUL:
      begin
        // shift accumulator and multiplier right as one.
        acc_next    = acc_sum[XLEN:1];
        mplier_next = {acc_sum[0], mplier_reg[XLEN-1:1]};
        cnt_next    = cnt_reg - 1'b1;
        if (cnt_reg == CNT_W'(1))
        begin
          state_next      = IDLE;
          o_booth_done    = 1'b1;
          o_booth_product = {acc_next, mplier_next};
        end
      end
      default:
        state_next = IDLE;
    endcase
  end

  a_done_in_mul: assert property (@(posedge i_booth_clk) disable iff (!i_booth_rstn)
    o_booth_done |-> (state_reg == MUL));

  a_cnt_no_underflow: assert property (@(posedge i_booth_clk) disable iff (!i_booth_rstn)
    (state_reg == MUL) |-> (cnt_reg != '0) ##1 (cnt_reg <= CNT_W'(XLEN)));

endmodule

//--- src/booth_sign_adjust.sv
`include "booth_defs.svh"

module booth_sign_adjust
(
  input  logic                     i_booth_clk,
  input  logic                     i_booth_rstn,
  input  logic                     i_start,
  input  booth_pkg::mul_req_t      i_req,
  output logic                     o_busy,
  output logic                     o_core_en,
  output logic [`BOOTH_XLEN-1:0]   o_core_a,
  output logic [`BOOTH_XLEN-1:0]   o_core_b,
  input  logic                     i_core_done,
  input  logic [2*`BOOTH_XLEN-1:0] i_core_product,
  output logic                     o_rsp_valid,
  output booth_pkg::mul_rsp_t      o_rsp
);

  localparam int XLEN = `BOOTH_XLEN;

  logic               a_signed;
  logic               b_signed;
  logic               a_neg;
  logic               b_neg;
  booth_pkg::mul_op_e op_q;
  logic               neg_q;
  logic [2*XLEN-1:0]  prod_adj;

  // which operands the op treats as signed.
  assign a_signed = (i_req.op == booth_pkg::MULH) || (i_req.op == booth_pkg::MULHSU);
  assign b_signed = (i_req.op == booth_pkg::MULH);
  assign a_neg    = a_signed & i_req.a[XLEN-1];
  assign b_neg    = b_signed & i_req.b[XLEN-1];

  // magnitudes, op and product sign.
  always_ff @(posedge i_booth_clk)
  begin
    if (i_start)
    begin
      o_core_a <= a_neg ? -i_req.a : i_req.a;
      o_core_b <= b_neg ? -i_req.b : i_req.b;
      op_q     <= i_req.op;
      neg_q    <= a_neg ^ b_neg;
    end
  end

  always_ff @(posedge i_booth_clk or negedge i_booth_rstn)
  begin
    if (!i_booth_rstn)
    begin
      o_busy      <= 1'b0;
      o_core_en   <= 1'b0;
      o_rsp_valid <= 1'b0;
    end
    else
    begin
      o_core_en   <= i_start;
      o_rsp_valid <= i_core_done;
      if (i_start)
        o_busy <= 1'b1;
      else if (i_core_done)
        o_busy <= 1'b0;
    end
  end

  assign prod_adj = neg_q ? -i_core_product : i_core_product;

  // low half for MUL, high half otherwise.
  always_ff @(posedge i_booth_clk)
  begin
    if (i_core_done)
      o_rsp.result <= (op_q == booth_pkg::MUL) ? prod_adj[XLEN-1:0]
                                               : prod_adj[2*XLEN-1:XLEN];
  end

  a_no_start_busy: assert property (@(posedge i_booth_clk) disable iff (!i_booth_rstn)
    i_start |-> !o_busy);

endmodule

//--- src/booth_wb_regs.sv
`include "booth_defs.svh"

module booth_wb_regs
(
  input  logic                    i_booth_clk,
  input  logic                    i_booth_rstn,
  input  logic                    i_wb_cyc,
  input  logic                    i_wb_stb,
  input  logic                    i_wb_we,
  input  logic [`BOOTH_ADR_W-1:0] i_wb_adr,
  input  logic [`BOOTH_XLEN-1:0]  i_wb_dat,
  output logic                    o_wb_ack,
  output logic [`BOOTH_XLEN-1:0]  o_wb_dat,
  input  logic                    i_busy,
  output logic                    o_start,
  output booth_pkg::mul_req_t     o_req,
  input  logic                    i_rsp_valid,
  input  booth_pkg::mul_rsp_t     i_rsp
);

  localparam int XLEN = `BOOTH_XLEN;

  logic            wb_req;
  logic            wb_wr;
  logic            start_ok;
  logic [XLEN-1:0] opa_q;
  logic [XLEN-1:0] opb_q;
  logic [XLEN-1:0] result_q;
  logic            done_q;

  // new cycle seen, ack on the next edge.
  assign wb_req   = i_wb_cyc & i_wb_stb & ~o_wb_ack;
  assign wb_wr    = wb_req & i_wb_we;
  assign start_ok = wb_wr & (i_wb_adr == `BOOTH_REG_CTRL) & ~i_busy;

  always_ff @(posedge i_booth_clk or negedge i_booth_rstn)
  begin
    if (!i_booth_rstn)
    begin
      o_wb_ack <= 1'b0;
      o_start  <= 1'b0;
      opa_q    <= '0;
      opb_q    <= '0;
      result_q <= '0;
      done_q   <= 1'b0;
    end
    else
    begin
      o_wb_ack <= wb_req;
      o_start  <= start_ok;
      if (wb_wr && (i_wb_adr == `BOOTH_REG_OPA))
        opa_q <= i_wb_dat;
      if (wb_wr && (i_wb_adr == `BOOTH_REG_OPB))
        opb_q <= i_wb_dat;
      if (i_rsp_valid)
      begin
        result_q <= i_rsp.result;
        done_q   <= 1'b1;
      end
      // a new start clears done.
      if (start_ok)
        done_q <= 1'b0;
    end
  end

  always_ff @(posedge i_booth_clk)
  begin
    if (start_ok)
    begin
      o_req.op <= booth_pkg::mul_op_e'(i_wb_dat[1:0]);
      o_req.a  <= opa_q;
      o_req.b  <= opb_q;
    end
  end

  // CTRL is write only.
  always_comb
  begin
    case (i_wb_adr)
      `BOOTH_REG_OPA:    o_wb_dat = opa_q;
      `BOOTH_REG_OPB:    o_wb_dat = opb_q;
      `BOOTH_REG_STATUS: o_wb_dat = {{(XLEN-2){1'b0}}, done_q, i_busy};
      `BOOTH_REG_RESULT: o_wb_dat = result_q;
      default:           o_wb_dat = '0;
    endcase
  end

  a_ack_single: assert property (@(posedge i_booth_clk) disable iff (!i_booth_rstn)
    o_wb_ack |=> !o_wb_ack);

endmodule

//--- src/booth_mul_top.sv
`include "booth_defs.svh"

module booth_mul_top
(
  input  logic                    i_booth_clk,
  input  logic                    i_booth_rstn,
  input  logic                    i_wb_cyc,
  input  logic                    i_wb_stb,
  input  logic                    i_wb_we,
  input  logic [`BOOTH_ADR_W-1:0] i_wb_adr,
  input  logic [`BOOTH_XLEN-1:0]  i_wb_dat,
  output logic                    o_wb_ack,
  output logic [`BOOTH_XLEN-1:0]  o_wb_dat
);

  logic                     busy;
  logic                     start;
  booth_pkg::mul_req_t      req;
  logic                     rsp_valid;
  booth_pkg::mul_rsp_t      rsp;
  logic                     core_en;
  logic [`BOOTH_XLEN-1:0]   core_a;
  logic [`BOOTH_XLEN-1:0]   core_b;
  logic                     core_done;
  logic [2*`BOOTH_XLEN-1:0] core_product;

  booth_wb_regs u_regs
  (
    .i_booth_clk  (i_booth_clk),
    .i_booth_rstn (i_booth_rstn),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_wb_we      (i_wb_we),
    .i_wb_adr     (i_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .o_wb_ack     (o_wb_ack),
    .o_wb_dat     (o_wb_dat),
    .i_busy       (busy),
    .o_start      (start),
    .o_req        (req),
    .i_rsp_valid  (rsp_valid),
    .i_rsp        (rsp)
  );

  booth_sign_adjust u_sign
  (
    .i_booth_clk    (i_booth_clk),
    .i_booth_rstn   (i_booth_rstn),
    .i_start        (start),
    .i_req          (req),
    .o_busy         (busy),
    .o_core_en      (core_en),
    .o_core_a       (core_a),
    .o_core_b       (core_b),
    .i_core_done    (core_done),
    .i_core_product (core_product),
    .o_rsp_valid    (rsp_valid),
    .o_rsp          (rsp)
  );

  riscv_core_booth #(.XLEN(`BOOTH_XLEN)) u_core
  (
    .i_booth_clk          (i_booth_clk),
    .i_booth_rstn         (i_booth_rstn),
    .i_booth_en           (core_en),
    .i_booth_multiplicand (core_a),
    .i_booth_multilpier   (core_b),
    .o_booth_done         (core_done),
    .o_booth_product      (core_product)
  );

endmodule

//--- tests/tb_clkgen.sv
module tb_clkgen
(
  output logic o_clk,
  output logic o_rstn
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period.
  initial
  begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // falling edge after time zero, then ten rising edges in reset.
  initial
  begin
    o_rstn = 1'b1;
    #1;
    o_rstn = 1'b0;
    repeat (10) @(posedge o_clk);
    #2;
    o_rstn = 1'b1;
  end

endmodule

//--- tests/tb_booth_checker.sv
`include "booth_defs.svh"

module tb_booth_checker
(
  input logic                    i_clk,
  input logic                    i_wb_cyc,
  input logic                    i_wb_stb,
  input logic                    i_wb_we,
  input logic [`BOOTH_ADR_W-1:0] i_wb_adr,
  input logic [`BOOTH_XLEN-1:0]  i_wb_wdat,
  input logic                    i_wb_ack,
  input logic [`BOOTH_XLEN-1:0]  i_wb_rdat
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int XLEN = `BOOTH_XLEN;

  string           test_name   = "reset_values";
  int              cycle_cnt   = 0;
  int              start_cycle = 0;
  bit              started     = 1'b0;
  int              check_count = 0;
  int              err_count   = 0;
  logic [XLEN-1:0] opa         = '0;
  logic [XLEN-1:0] opb         = '0;
  logic [XLEN-1:0] res_prev    = '0;
  logic [XLEN-1:0] res_new     = '0;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic print_summary();
    $display("checks: %0d, errors: %0d", check_count, err_count);
  endtask

  // full 128-bit product, then the half the op asks for.
  function automatic logic [XLEN-1:0] ref_result(input logic [1:0]      op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    logic        [2*XLEN-1:0] ua;
    logic        [2*XLEN-1:0] ub;
    logic        [2*XLEN-1:0] prod;
    sa = {{XLEN{a[XLEN-1]}}, a};
    sb = {{XLEN{b[XLEN-1]}}, b};
    ua = {{XLEN{1'b0}}, a};
    ub = {{XLEN{1'b0}}, b};
    case (op)
      booth_pkg::MULH:   prod = sa * sb;
      booth_pkg::MULHSU: prod = sa * $signed(ub);
      default:           prod = ua * ub;
    endcase
    if (op == booth_pkg::MUL)
      return prod[XLEN-1:0];
    return prod[2*XLEN-1:XLEN];
  endfunction

  // busy from the edge after the CTRL ack until rsp_valid.
  function automatic bit busy_at(input int c);
    return started && (c > start_cycle) && (c <= start_cycle + XLEN + 1);
  endfunction

  function automatic bit done_at(input int c);
    return started && (c >= start_cycle + XLEN + 3);
  endfunction

  task automatic record_write(input logic [`BOOTH_ADR_W-1:0] adr, input logic [XLEN-1:0] dat);
    case (adr)
      `BOOTH_REG_OPA: opa = dat;
      `BOOTH_REG_OPB: opb = dat;
      `BOOTH_REG_CTRL:
      begin
        // dropped when the unit was busy before this edge.
        if (!busy_at(cycle_cnt - 1))
        begin
          res_prev    = done_at(cycle_cnt) ? res_new : res_prev;
          res_new     = ref_result(dat[1:0], opa, opb);
          start_cycle = cycle_cnt;
          started     = 1'b1;
        end
      end
      default: ;
    endcase
  endtask

  task automatic check_read(input logic [`BOOTH_ADR_W-1:0] adr, input logic [XLEN-1:0] act);
    logic [XLEN-1:0] exp_val;
    case (adr)
      `BOOTH_REG_OPA:    exp_val = opa;
      `BOOTH_REG_OPB:    exp_val = opb;
      `BOOTH_REG_STATUS: exp_val = {{(XLEN-2){1'b0}}, done_at(cycle_cnt), busy_at(cycle_cnt)};
      `BOOTH_REG_RESULT: exp_val = done_at(cycle_cnt) ? res_new : res_prev;
      default:           exp_val = '0;
    endcase
    check_count++;
    if (act !== exp_val)
    begin
      err_count++;
      $display("Fail %s: register %0d at cycle %0d expected %h actual %h",
               test_name, adr, cycle_cnt, exp_val, act);
    end
  endtask

  always @(posedge i_clk)
    cycle_cnt <= cycle_cnt + 1;

  // mid-cycle, the ack and the bus fields are settled.
  always @(negedge i_clk)
  begin
    if (i_wb_cyc && i_wb_stb && i_wb_ack)
    begin
      if (i_wb_we)
        record_write(i_wb_adr, i_wb_wdat);
      else
        check_read(i_wb_adr, i_wb_rdat);
    end
  end

endmodule

//--- tests/tb_booth_top.sv
`include "booth_defs.svh"

module tb_booth_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int              XLEN           = `BOOTH_XLEN;
  localparam int              TIMEOUT_CYCLES = 210 * (XLEN + 20) + 100;
  localparam logic [XLEN-1:0] ONES           = '1;
  localparam logic [XLEN-1:0] MIN_NEG        = {1'b1, {(XLEN-1){1'b0}}};

  logic                    clk;
  logic                    rstn;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [`BOOTH_ADR_W-1:0] wb_adr;
  logic [XLEN-1:0]         wb_wdat;
  logic                    wb_ack;
  logic [XLEN-1:0]         wb_rdat;
  int                      cycle = 0;
  int                      ack_cycle;
  integer                  seed;
  logic [XLEN-1:0]         rdata;
  logic [XLEN-1:0]         corner_a [5];
  logic [XLEN-1:0]         corner_b [5];

  tb_clkgen u_clkgen
  (
    .o_clk  (clk),
    .o_rstn (rstn)
  );

  booth_mul_top u_dut
  (
    .i_booth_clk  (clk),
    .i_booth_rstn (rstn),
    .i_wb_cyc     (wb_cyc),
    .i_wb_stb     (wb_stb),
    .i_wb_we      (wb_we),
    .i_wb_adr     (wb_adr),
    .i_wb_dat     (wb_wdat),
    .o_wb_ack     (wb_ack),
    .o_wb_dat     (wb_rdat)
  );

  tb_booth_checker u_chk
  (
    .i_clk     (clk),
    .i_wb_cyc  (wb_cyc),
    .i_wb_stb  (wb_stb),
    .i_wb_we   (wb_we),
    .i_wb_adr  (wb_adr),
    .i_wb_wdat (wb_wdat),
    .i_wb_ack  (wb_ack),
    .i_wb_rdat (wb_rdat)
  );

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      u_chk.print_summary();
      $display("test failed");
      $finish;
    end
  end

  // ack is seen mid-cycle, stb drops 2 ns after the next edge.
  task automatic finish_access();
    do
      @(negedge clk);
    while (!wb_ack);
    ack_cycle = cycle;
    rdata     = wb_rdat;
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input logic [`BOOTH_ADR_W-1:0] adr, input logic [XLEN-1:0] dat);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = 1'b1;
    wb_adr  = adr;
    wb_wdat = dat;
    finish_access();
  endtask

  task automatic read_reg(input logic [`BOOTH_ADR_W-1:0] adr);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    finish_access();
  endtask

  task automatic wait_until_cycle(input int n);
    while (cycle < n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_done();
    do
      read_reg(`BOOTH_REG_STATUS);
    while (!rdata[`BOOTH_STAT_DONE]);
  endtask

  task automatic start_mul(input logic [1:0] op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
    write_reg(`BOOTH_REG_OPA, a);
    write_reg(`BOOTH_REG_OPB, b);
    write_reg(`BOOTH_REG_CTRL, {{(XLEN-2){1'b0}}, op});
  endtask

  task automatic run_mul(input logic [1:0] op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
    start_mul(op, a, b);
    wait_done();
    read_reg(`BOOTH_REG_RESULT);
  endtask

  task automatic random_ops(input logic [1:0] op, input int count);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    repeat (count)
    begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      run_mul(op, a, b);
    end
  endtask

  initial
  begin
    int start_ack;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    seed    = 32'h8edcb71a;
    corner_a = '{'0, {{(XLEN-1){1'b0}}, 1'b1}, ONES, MIN_NEG, MIN_NEG};
    corner_b = '{ONES, ONES, ONES, ONES, MIN_NEG};
    wait (rstn === 1'b1);
    @(posedge clk);
    #2;

    u_chk.set_test("reset_values");
    read_reg(`BOOTH_REG_STATUS);
    read_reg(`BOOTH_REG_RESULT);

    u_chk.set_test("random_mulhu");
    random_ops(booth_pkg::MULHU, 50);
    u_chk.set_test("random_mul");
    random_ops(booth_pkg::MUL, 50);
    u_chk.set_test("random_mulh");
    random_ops(booth_pkg::MULH, 50);
    u_chk.set_test("random_mulhsu");
    random_ops(booth_pkg::MULHSU, 50);

    u_chk.set_test("corner_operands");
    for (int k = 0; k < 4; k++)
      for (int i = 0; i < 5; i++)
        run_mul(k[1:0], corner_a[i], corner_b[i]);

    // busy right after the ack, done not before XLEN+3 cycles.
    u_chk.set_test("done_timing");
    start_mul(booth_pkg::MULH, {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
    start_ack = ack_cycle;
    read_reg(`BOOTH_REG_STATUS);
    wait_until_cycle(start_ack + XLEN + 1);
    read_reg(`BOOTH_REG_STATUS);
    wait_done();
    read_reg(`BOOTH_REG_RESULT);
    start_mul(booth_pkg::MUL, {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
    start_ack = ack_cycle;
    wait_until_cycle(start_ack + XLEN + 2);
    read_reg(`BOOTH_REG_STATUS);
    read_reg(`BOOTH_REG_RESULT);

    // second CTRL write lands while busy.
    u_chk.set_test("ctrl_while_busy");
    start_mul(booth_pkg::MULHSU, {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
    start_mul(booth_pkg::MULHU, {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
    wait_done();
    read_reg(`BOOTH_REG_RESULT);

    u_chk.print_summary();
    if (u_chk.err_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+src
src/booth_pkg.sv
src/riscv_core_booth.sv
src/booth_sign_adjust.sv
src/booth_wb_regs.sv
src/booth_mul_top.sv
tests/tb_clkgen.sv
tests/tb_booth_checker.sv
tests/tb_booth_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_booth_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
